// ==== verilog/ahb_stage_pkg.sv ====
// Shared AHB widths, encodings and types, imported by the input stage RTL and its testbench
package ahb_stage_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  localparam int ADDR_W    = 32; // HADDR width
  localparam int WRAP_BITS = 4;  // Beat offset width, enough for WRAP16

  typedef logic [ADDR_W-1:0] addr_t;  // Address bus
  typedef logic [2:0]        hsize_t; // HSIZE code

  // Size codes used when scaling the address to a beat offset
  localparam hsize_t SIZE_BYTE  = 3'b000;
  localparam hsize_t SIZE_HALF  = 3'b001;
  localparam hsize_t SIZE_WORD  = 3'b010;
  localparam hsize_t SIZE_DWORD = 3'b011;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00, // No transfer
    BUSY   = 2'b01, // Master pauses inside a burst
    NONSEQ = 2'b10, // Single or first beat
    SEQ    = 2'b11  // Following beat of a burst
  } htrans_e;

  typedef enum logic [2:0] {
    SINGLE = 3'b000, // Single transfer
    INCR   = 3'b001, // Undefined length incrementing
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // Slave response, only OKAY is generated locally
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,
    SPLIT = 2'b11
  } hresp_e;

endpackage

// ==== verilog/hold_if.sv ====
// Held transfer and pending state passed from the holding stage to the output selector
`timescale 1ns/100ps

interface hold_if;

  import ahb_stage_pkg::*;

  logic    pending;    // Held transfer waiting for output stage
  logic    data_valid; // Data phase of a valid transfer on this port
  addr_t   h_addr;     // Captured HADDR
  logic    h_write;    // Captured HWRITE
  hsize_t  h_size;     // Captured HSIZE
  hburst_e h_burst;    // Captured HBURST
  htrans_e h_trans;    // Captured HTRANS, burst rewrite only

  // Holding stage side
  modport hold (
    output pending, data_valid,
    output h_addr, h_write, h_size, h_burst, h_trans
  );

  // Output selector side
  modport sel (
    input pending, data_valid,
    input h_addr, h_write, h_size, h_burst, h_trans
  );

endinterface

// ==== verilog/ahb_hold_stage.sv ====
// Address phase capture for one matrix slave port, keeps the pending and data-phase flags
`timescale 1ns/100ps

module ahb_hold_stage (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSELS,       // Port select
  input  ahb_stage_pkg::addr_t  HADDRS,
  input  ahb_stage_pkg::htrans_e HTRANSS,
  input  logic                  HWRITES,
  input  ahb_stage_pkg::hsize_t HSIZES,
  input  ahb_stage_pkg::hburst_e HBURSTS,
  input  logic                  HREADYS,     // Previous transfer done
  input  logic                  active_ip,   // Output stage drives this port
  input  logic                  readyout_ip, // Output stage data-phase ready
  output logic                  accept,      // Holding register load strobe
  output logic                  held_tran_ip, // Request to output stage
  hold_if.hold                  hold
);

  import ahb_stage_pkg::*;

  logic    addr_valid; // Active address phase to this port
  logic    pend_next;
  logic    pend_q;
  logic    dv_q;
  addr_t   reg_addr;
  logic    reg_write;
  hsize_t  reg_size;
  hburst_e reg_burst;
  htrans_e reg_trans;

  // ----------------------------------------------------------
  // Address phase decode
  // ----------------------------------------------------------
  // IDLE and BUSY carry no transfer
  assign addr_valid = HSELS && ((HTRANSS == NONSEQ) || (HTRANSS == SEQ));
  assign accept     = addr_valid && HREADYS;

  // Holding registers, loaded on every accepted address phase
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      reg_addr  <= HADDRS;
      reg_write <= HWRITES;
      reg_size  <= HSIZES;
      reg_burst <= HBURSTS;
      reg_trans <= HTRANSS;
    end
  end

  // ----------------------------------------------------------
  // Pending transfer
  // ----------------------------------------------------------
  // Set when output stage is not ours at accept
  // Cleared once it drives us and completes
  always_comb
  begin
    if (accept && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && readyout_ip)
      pend_next = 1'b0;
    else
      pend_next = pend_q;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_q <= 1'b0;
    else
      pend_q <= pend_next;
  end

  // Data phase flag follows the address phase on HREADYS
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      dv_q <= 1'b0;
    else if (HREADYS)
      dv_q <= addr_valid; // Frozen while bus stalled
  end

  assign held_tran_ip = accept || pend_q; // Direct or held request

  // Towards the output selector
  assign hold.pending    = pend_q;
  assign hold.data_valid = dv_q;
  assign hold.h_addr     = reg_addr;
  assign hold.h_write    = reg_write;
  assign hold.h_size     = reg_size;
  assign hold.h_burst    = reg_burst;
  assign hold.h_trans    = reg_trans;

endmodule

// ==== verilog/ahb_burst_track.sv ====
// Early burst termination and wrap boundary tracking for bursts entering the input stage
`timescale 1ns/100ps

module ahb_burst_track (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  ahb_stage_pkg::addr_t   HADDRS,
  input  ahb_stage_pkg::htrans_e HTRANSS,
  input  ahb_stage_pkg::hsize_t  HSIZES,
  input  ahb_stage_pkg::hburst_e HBURSTS,
  input  logic                   HREADYS,
  input  logic                   accept,    // Address phase taken by this port
  input  logic                   active_ip, // Output stage drives this port
  output logic                   override,  // Burst being completed as INCR
  output logic                   bound      // Last beat before wrap point seen
);

  import ahb_stage_pkg::*;

  logic                 override_next;
  logic [WRAP_BITS-1:0] offset_addr; // Beat index inside 16-beat window
  logic [WRAP_BITS-1:0] check_addr;  // Offset with non-wrapping bits forced high
  logic                 bound_next;
  logic                 bound_en;

  // ----------------------------------------------------------
  // Early termination
  // ----------------------------------------------------------
  // A new burst or idle ends the override
  always_comb
  begin
    if ((HTRANSS == NONSEQ) || (HTRANSS == IDLE))
      override_next = 1'b0;
    else if ((HTRANSS == SEQ) && accept && !active_ip)
      override_next = 1'b1; // Burst broken by output stage
    else
      override_next = override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override <= 1'b0;
    else if (HREADYS)
      override <= override_next;
  end

  // ----------------------------------------------------------
  // Wrap boundary
  // ----------------------------------------------------------
  always_comb
  begin
    case (HSIZES)
      SIZE_BYTE  : offset_addr = HADDRS[WRAP_BITS-1:0];
      SIZE_HALF  : offset_addr = HADDRS[WRAP_BITS:1];
      SIZE_WORD  : offset_addr = HADDRS[WRAP_BITS+1:2];
      SIZE_DWORD : offset_addr = HADDRS[WRAP_BITS+2:3];
      default    : offset_addr = HADDRS[WRAP_BITS-1:0]; // 128 bits and up
    endcase
  end

  // Only the bits inside the wrap length are compared
  always_comb
  begin
    case (HBURSTS)
      WRAP4   : check_addr = {2'b11, offset_addr[1:0]};
      WRAP8   : check_addr = {1'b1, offset_addr[2:0]};
      WRAP16  : check_addr = offset_addr;
      default : check_addr = '0; // Never a boundary
    endcase
  end

  assign bound_next = &check_addr;
  assign bound_en   = HREADYS && ((HTRANSS == NONSEQ) || (HTRANSS == SEQ));

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

endmodule

// ==== verilog/ahb_out_select.sv ====
// Direct or held transfer selection towards the output stage, plus the upstream response
`timescale 1ns/100ps

module ahb_out_select (
  input  logic                   HSELS,
  input  ahb_stage_pkg::addr_t   HADDRS,
  input  ahb_stage_pkg::htrans_e HTRANSS,
  input  logic                   HWRITES,
  input  ahb_stage_pkg::hsize_t  HSIZES,
  input  ahb_stage_pkg::hburst_e HBURSTS,
  hold_if.sel                    hold,
  input  logic                   override,    // Interrupted burst in progress
  input  logic                   bound,       // Wrap point reached
  input  logic                   readyout_ip, // Output stage ready
  input  ahb_stage_pkg::hresp_e  resp_ip,     // Output stage response
  output logic                   sel_ip,
  output ahb_stage_pkg::addr_t   addr_ip,
  output ahb_stage_pkg::htrans_e trans_ip,
  output logic                   write_ip,
  output ahb_stage_pkg::hsize_t  size_ip,
  output ahb_stage_pkg::hburst_e burst_ip,
  output logic                   HREADYOUTS,
  output ahb_stage_pkg::hresp_e  HRESPS
);

  import ahb_stage_pkg::*;

  htrans_e trans_int; // Selected HTRANS before boundary rewrite
  hburst_e burst_int; // Selected HBURST before override
  htrans_e transb;    // HTRANS that decides the burst rewrite

  // ----------------------------------------------------------
  // Transfer mux
  // ----------------------------------------------------------
  always_comb
  begin
    if (!hold.pending)
    begin
      sel_ip    = HSELS;   // Straight through
      addr_ip   = HADDRS;
      trans_int = HTRANSS;
      write_ip  = HWRITES;
      size_ip   = HSIZES;
      burst_int = HBURSTS;
      transb    = HTRANSS;
    end
    else
    begin
      sel_ip    = 1'b1;    // Held transfer always selected
      addr_ip   = hold.h_addr;
      trans_int = NONSEQ;  // Restarts at the output stage
      write_ip  = hold.h_write;
      size_ip   = hold.h_size;
      burst_int = hold.h_burst;
      transb    = hold.h_trans;
    end
  end

  // Past the wrap point an INCR continuation must restart
  always_comb
  begin
    trans_ip = trans_int;
    if (override && bound)
    begin
      case (trans_int)
        SEQ     : trans_ip = NONSEQ;
        BUSY    : trans_ip = IDLE;
        default : trans_ip = trans_int;
      endcase
    end
  end

  assign burst_ip = (override && (transb != NONSEQ)) ? INCR : burst_int;

  // ----------------------------------------------------------
  // Upstream response
  // ----------------------------------------------------------
  always_comb
  begin
    if (!hold.data_valid)
    begin
      HREADYOUTS = 1'b1; // Not selected, or IDLE/BUSY
      HRESPS     = OKAY;
    end
    else if (hold.pending)
    begin
      HREADYOUTS = 1'b0; // Stall master until taken
      HRESPS     = OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

endmodule

// ==== verilog/ahb_input_stage.sv ====
// Bus matrix input stage top, holds a transfer on one slave port until its output stage is free
`timescale 1ns/100ps

module ahb_input_stage (
  // AHB clock and reset
  input  logic                   HCLK,
  input  logic                   HRESETn,

  // Upstream address and control
  input  logic                   HSELS,
  input  ahb_stage_pkg::addr_t   HADDRS,
  input  ahb_stage_pkg::htrans_e HTRANSS,
  input  logic                   HWRITES,
  input  ahb_stage_pkg::hsize_t  HSIZES,
  input  ahb_stage_pkg::hburst_e HBURSTS,
  input  logic                   HREADYS,

  // From the output stage
  input  logic                   active_ip,
  input  logic                   readyout_ip,
  input  ahb_stage_pkg::hresp_e  resp_ip,

  // Upstream response
  output logic                   HREADYOUTS,
  output ahb_stage_pkg::hresp_e  HRESPS,

  // To the output stage
  output logic                   sel_ip,
  output ahb_stage_pkg::addr_t   addr_ip,
  output ahb_stage_pkg::htrans_e trans_ip,
  output logic                   write_ip,
  output ahb_stage_pkg::hsize_t  size_ip,
  output ahb_stage_pkg::hburst_e burst_ip,
  output logic                   held_tran_ip
);

  logic accept;   // Load strobe from holding stage
  logic override; // Burst continuation as INCR
  logic bound;    // Wrap boundary flag

  hold_if u_hold_if ();

  // Captures address phases and tracks pending state
  ahb_hold_stage u_hold_stage (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HADDRS       (HADDRS),
    .HTRANSS      (HTRANSS),
    .HWRITES      (HWRITES),
    .HSIZES       (HSIZES),
    .HBURSTS      (HBURSTS),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .accept       (accept),
    .held_tran_ip (held_tran_ip),
    .hold         (u_hold_if.hold)
  );

  ahb_burst_track u_burst_track (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HADDRS    (HADDRS),
    .HTRANSS   (HTRANSS),
    .HSIZES    (HSIZES),
    .HBURSTS   (HBURSTS),
    .HREADYS   (HREADYS),
    .accept    (accept),
    .active_ip (active_ip),
    .override  (override),
    .bound     (bound)
  );

  // Combinational, zero latency
  ahb_out_select u_out_select (
    .HSELS       (HSELS),
    .HADDRS      (HADDRS),
    .HTRANSS     (HTRANSS),
    .HWRITES     (HWRITES),
    .HSIZES      (HSIZES),
    .HBURSTS     (HBURSTS),
    .hold        (u_hold_if.sel),
    .override    (override),
    .bound       (bound),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .sel_ip      (sel_ip),
    .addr_ip     (addr_ip),
    .trans_ip    (trans_ip),
    .write_ip    (write_ip),
    .size_ip     (size_ip),
    .burst_ip    (burst_ip),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS)
  );

endmodule

// ==== verification/tb_ref_model.svh ====
// Reference model of the input stage and typed compare tasks for the testbench top to include
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected DUT outputs for one cycle
typedef struct packed {
  logic    sel;
  addr_t   addr;
  htrans_e trans;
  logic    write;
  hsize_t  size;
  hburst_e burst;
  logic    ready;
  hresp_e  resp;
  logic    held;
} expect_t;

// ------------------------------------------------------------
// Model state mirroring the DUT registers
// ------------------------------------------------------------
logic    m_pending  = 1'b0;
logic    m_dv       = 1'b0; // Data phase of a valid transfer
logic    m_override = 1'b0;
logic    m_bound    = 1'b0;
addr_t   m_addr;            // Holding contents
logic    m_write;
hsize_t  m_size;
hburst_e m_burst;
htrans_e m_trans;
hburst_e m_bound_burst;     // Burst and size of the beat that last set bound
hsize_t  m_bound_size;

function automatic logic valid_trans(htrans_e t);
  return (t == NONSEQ) || (t == SEQ);
endfunction

function automatic logic is_accept();
  return HSELS && valid_trans(HTRANSS) && HREADYS;
endfunction

// Last beat before the wrap point by beat number inside the wrap window
function automatic logic wrap_last_beat(addr_t a, hsize_t s, hburst_e b);
  addr_t      beat;
  logic [3:0] mask;
  beat = (s <= 3'd3) ? (a >> s) : a; // 128 bits and up keep the byte offset
  case (b)
    WRAP4   : mask = 4'h3;
    WRAP8   : mask = 4'h7;
    WRAP16  : mask = 4'hf;
    default : mask = 4'h0; // Incrementing bursts never wrap
  endcase
  return (mask != 4'h0) && ((beat[3:0] & mask) == mask);
endfunction

function automatic expect_t calc_expected();
  expect_t e;
  htrans_e tdec; // HTRANS that picks the burst rewrite
  hburst_e bsel;
  if (m_pending)
  begin
    e.sel   = 1'b1;
    e.addr  = m_addr;
    e.trans = NONSEQ; // Held transfer restarts
    e.write = m_write;
    e.size  = m_size;
    bsel    = m_burst;
    tdec    = m_trans;
  end
  else
  begin
    e.sel   = HSELS;
    e.addr  = HADDRS;
    e.trans = HTRANSS;
    e.write = HWRITES;
    e.size  = HSIZES;
    bsel    = HBURSTS;
    tdec    = HTRANSS;
  end
  if (m_override && m_bound && (e.trans == SEQ))
    e.trans = NONSEQ;
  else if (m_override && m_bound && (e.trans == BUSY))
    e.trans = IDLE;
  e.burst = (m_override && (tdec != NONSEQ)) ? INCR : bsel;
  e.ready = !m_dv || (!m_pending && readyout_ip);
  e.resp  = (m_dv && !m_pending) ? resp_ip : OKAY;
  e.held  = is_accept() || m_pending;
  return e;
endfunction

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic check_trans(input htrans_e got_t, input htrans_e exp_t,
                           input hburst_e got_b, input hburst_e exp_b);
  if (got_t !== exp_t)
  begin
    $display("mismatch trans_ip: got 0x%h, expected 0x%h", got_t, exp_t);
    abort_run();
  end
  else if (got_b !== exp_b)
  begin
    $display("mismatch burst_ip: got 0x%h, expected 0x%h", got_b, exp_b);
    abort_run();
  end
endtask

task automatic check_resp(input logic got_r, input logic exp_r,
                          input hresp_e got_p, input hresp_e exp_p);
  if (got_r !== exp_r)
  begin
    $display("mismatch HREADYOUTS: got 0x%h, expected 0x%h", got_r, exp_r);
    abort_run();
  end
  else if (got_p !== exp_p)
  begin
    $display("mismatch HRESPS: got 0x%h, expected 0x%h", got_p, exp_p);
    abort_run();
  end
endtask

task automatic check_xfer(input logic   got_sel,   input logic   exp_sel,
                          input addr_t  got_addr,  input addr_t  exp_addr,
                          input logic   got_write, input logic   exp_write,
                          input hsize_t got_size,  input hsize_t exp_size,
                          input logic   got_held,  input logic   exp_held);
  if (got_sel !== exp_sel)
  begin
    $display("mismatch sel_ip: got 0x%h, expected 0x%h", got_sel, exp_sel);
    abort_run();
  end
  else if (got_addr !== exp_addr)
  begin
    $display("mismatch addr_ip: got 0x%h, expected 0x%h", got_addr, exp_addr);
    abort_run();
  end
  else if (got_write !== exp_write)
  begin
    $display("mismatch write_ip: got 0x%h, expected 0x%h", got_write, exp_write);
    abort_run();
  end
  else if (got_size !== exp_size)
  begin
    $display("mismatch size_ip: got 0x%h, expected 0x%h", got_size, exp_size);
    abort_run();
  end
  else if (got_held !== exp_held)
  begin
    $display("mismatch held_tran_ip: got 0x%h, expected 0x%h", got_held, exp_held);
    abort_run();
  end
endtask

`endif

// ==== verification/tb_ahb_input_stage.sv ====
// Random stimulus testbench for the AHB input stage that compares every cycle with a reference model
`timescale 1ns/100ps

module tb_ahb_input_stage;

  import ahb_stage_pkg::*;

  localparam int NUM_CYCLES = 30000; // Random cycles after reset
  localparam int WAIT_LIMIT = 200;   // Cycles allowed for any wait

  logic    HCLK;
  logic    HRESETn;
  logic    HSELS;
  addr_t   HADDRS;
  htrans_e HTRANSS;
  logic    HWRITES;
  hsize_t  HSIZES;
  hburst_e HBURSTS;
  logic    HREADYS;
  logic    active_ip;
  logic    readyout_ip;
  hresp_e  resp_ip;
  logic    HREADYOUTS;
  hresp_e  HRESPS;
  logic    sel_ip;
  addr_t   addr_ip;
  htrans_e trans_ip;
  logic    write_ip;
  hsize_t  size_ip;
  hburst_e burst_ip;
  logic    held_tran_ip;

  integer seed;
  logic   model_ready = 1'b0;        // Model has seen a reset edge
  int     n_checked   = 0;
  int     rewrite_hits [3][3] = '{default: 0}; // Boundary rewrites by wrap burst and size

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  `include "tb_ref_model.svh"

  ahb_input_stage DUT (.*);

  // ------------------------------------------------------------
  // Model update at the coming rising edge
  // ------------------------------------------------------------
  task automatic update_model();
    logic acc;
    acc = is_accept();
    if (acc)
    begin
      m_addr  = HADDRS; // Copy of the holding registers
      m_write = HWRITES;
      m_size  = HSIZES;
      m_burst = HBURSTS;
      m_trans = HTRANSS;
    end
    if (!HRESETn)
    begin
      m_pending   = 1'b0;
      m_dv        = 1'b0;
      m_override  = 1'b0;
      m_bound     = 1'b0;
      model_ready = 1'b1;
    end
    else
    begin
      if (acc && !active_ip)
        m_pending = 1'b1;
      else if (active_ip && readyout_ip)
        m_pending = 1'b0;
      if (HREADYS)
      begin
        m_dv = HSELS && valid_trans(HTRANSS);
        if ((HTRANSS == NONSEQ) || (HTRANSS == IDLE))
          m_override = 1'b0;
        else if ((HTRANSS == SEQ) && acc && !active_ip)
          m_override = 1'b1;
        if (valid_trans(HTRANSS))
        begin
          m_bound       = wrap_last_beat(HADDRS, HSIZES, HBURSTS);
          m_bound_burst = HBURSTS;
          m_bound_size  = HSIZES;
        end
      end
    end
  endtask

  // Counts rewrites of SEQ or BUSY on the direct path
  task automatic note_rewrite();
    logic [1:0] b;
    if (m_override && m_bound && !m_pending && (m_bound_size < 3'd3)
        && ((HTRANSS == SEQ) || (HTRANSS == BUSY)))
    begin
      case (m_bound_burst)
        WRAP4   : b = 2'd0;
        WRAP8   : b = 2'd1;
        default : b = 2'd2;
      endcase
      rewrite_hits[b][m_bound_size[1:0]]++;
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r = $random(seed);
    HSELS = (r[1:0] != 2'b00); // Mostly selected
    r = $random(seed);
    HTRANSS = htrans_e'(r[1:0]);
    r = $random(seed);
    HADDRS = r;
    r = $random(seed);
    if (r[0])
      HADDRS[7:0] = 8'hff; // Bias towards wrap points
    r = $random(seed);
    HWRITES = r[0];
    r = $random(seed);
    HSIZES = (r[3:2] != 2'b11) ? hsize_t'(r[1:0] % 2'd3) : hsize_t'(r[6:4]);
    r = $random(seed);
    HBURSTS = hburst_e'(r[2:0]);
    r = $random(seed);
    HREADYS = (r[1:0] != 2'b00);
    r = $random(seed);
    active_ip = r[0];
    r = $random(seed);
    readyout_ip = (r[1:0] != 2'b00);
    r = $random(seed);
    resp_ip = hresp_e'(r[1:0]);
  endtask

  // ------------------------------------------------------------
  // Clock, stimulus and compare
  // ------------------------------------------------------------
  initial
  begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK; // 40 ns period
  end

  initial
  begin
    int waited;
    int missing;
    seed        = 77469;
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = IDLE;
    HWRITES     = 1'b0;
    HSIZES      = 3'd0;
    HBURSTS     = SINGLE;
    HREADYS     = 1'b1;
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = OKAY;
    repeat (10) @(negedge HCLK);
    HRESETn = 1'b1;
    waited  = 0;
    while (!model_ready)
    begin
      @(negedge HCLK);
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("Timeout while waiting for the reset to reach the reference model");
        abort_run();
      end
    end
    repeat (NUM_CYCLES)
    begin
      drive_random();
      @(negedge HCLK);
    end
    waited = 0;
    while (n_checked < NUM_CYCLES)
    begin
      @(negedge HCLK);
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("Timeout while waiting for the compare process to finish");
        abort_run();
      end
    end
    missing = 0;
    for (logic [1:0] b = 2'd0; b < 2'd3; b++)
      for (logic [1:0] s = 2'd0; s < 2'd3; s++)
        if (rewrite_hits[b][s] == 0)
        begin
          $display("No boundary rewrite was seen for WRAP%0d at size code %0d", 4 << b, s);
          missing++;
        end
    if (missing != 0)
      abort_run();
    else
    begin
      $display("Done: no errors");
      $finish;
    end
  end

  // Sample 1 ns before each rising edge and advance the model
  initial
  begin
    expect_t e;
    forever
    begin
      @(negedge HCLK);
      #19;
      if (HRESETn && model_ready)
      begin
        e = calc_expected();
        check_xfer(sel_ip, e.sel, addr_ip, e.addr, write_ip, e.write,
                   size_ip, e.size, held_tran_ip, e.held);
        check_trans(trans_ip, e.trans, burst_ip, e.burst);
        check_resp(HREADYOUTS, e.ready, HRESPS, e.resp);
        note_rewrite();
        n_checked++;
      end
      update_model();
    end
  end

endmodule

// ==== tb.f ====
+incdir+verification
verilog/ahb_stage_pkg.sv
verilog/hold_if.sv
verilog/ahb_hold_stage.sv
verilog/ahb_burst_track.sv
verilog/ahb_out_select.sv
verilog/ahb_input_stage.sv
verification/tb_ahb_input_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_ahb_input_stage
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
